// ==== include/cr_params.svh ====
`ifndef CR_PARAMS_SVH
`define CR_PARAMS_SVH

// Hardware threads in this core
`define CR_THREADS 4

// External interrupt request lines
`define CR_NUM_INTERRUPTS 16

// Address space ID width
`define CR_ASID_WIDTH 8

// Queue depths, also the initial credit counts on each side
`define CR_REQ_DEPTH 4
`define CR_RSP_DEPTH 4

// Core number, reported in the upper bits of THREAD_ID
`define CR_CORE_ID 2

`endif

// ==== design/cr_pkg.sv ====
`include "cr_params.svh"

package cr_pkg;
    typedef logic [31:0] scalar_t;
    typedef logic [$clog2(`CR_THREADS) - 1:0] thread_idx_t;
    typedef logic [3:0] subcycle_t;

    typedef enum logic [3:0] {
        TT_RESET, TT_ILLEGAL, TT_INTERRUPT,
        TT_TLB_MISS, TT_PAGE_FAULT, TT_SYSCALL
    } trap_type_t;

    typedef struct packed {
        logic is_store;
        logic is_cache_control;
        trap_type_t trap_type;
    } trap_cause_t;

    localparam trap_cause_t TRAP_CAUSE_RESET = '{
        is_store: 1'b0,
        is_cache_control: 1'b0,
        trap_type: TT_RESET
    };

    typedef enum logic [4:0] {
        CR_THREAD_ID = 5'd0, CR_TRAP_HANDLER = 5'd1, CR_TRAP_PC = 5'd2,
        CR_TRAP_CAUSE = 5'd3, CR_FLAGS = 5'd4, CR_TRAP_ADDRESS = 5'd5,
        CR_CYCLE_COUNT = 5'd6, CR_TLB_MISS_HANDLER = 5'd7, CR_SAVED_FLAGS = 5'd8,
        CR_CURRENT_ASID = 5'd9, CR_PAGE_DIR = 5'd10, CR_SCRATCHPAD0 = 5'd11,
        CR_SCRATCHPAD1 = 5'd12, CR_SUBCYCLE = 5'd13, CR_INTERRUPT_MASK = 5'd14,
        CR_INTERRUPT_ACK = 5'd15, CR_INTERRUPT_PENDING = 5'd16,
        CR_INTERRUPT_TRIGGER = 5'd17
    } control_register_t;

    typedef struct packed {
        logic write;
        thread_idx_t thread;
        control_register_t index;
        scalar_t value;
    } creg_req_t;

    typedef struct packed {
        thread_idx_t thread;
        control_register_t index;
        scalar_t data;
    } creg_rsp_t;

    typedef struct packed {
        thread_idx_t thread;
        trap_cause_t cause;
        scalar_t pc;
        scalar_t access_addr;
        subcycle_t subcycle;
    } trap_event_t;

    // Bit 2 supervisor, bit 1 MMU, bit 0 interrupts
    typedef struct packed {
        logic supervisor;
        logic mmu_en;
        logic interrupt_en;
    } flags_t;
endpackage

// ==== design/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 4
) (
    input                 clk,
    input                 reset,
    input                 push,
    input payload_t       push_data,
    input                 pop,
    output payload_t      pop_data,
    output logic          not_empty,
    output logic          full,
    output logic          credit_return
);
    localparam int PTR_W = DEPTH > 1 ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t entries[DEPTH];
    logic [PTR_W - 1:0] rd_ptr;
    logic [PTR_W - 1:0] wr_ptr;
    logic [CNT_W - 1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && not_empty;
    assign not_empty = count != '0;
    assign full = count == CNT_W'(DEPTH);
    assign pop_data = entries[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            entries[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            // Pointers wrap at DEPTH, which need not be a power of two
            if (do_push)
                wr_ptr <= wr_ptr == PTR_W'(DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr == PTR_W'(DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
            credit_return <= do_pop;
        end
    end
endmodule

// ==== design/interrupt_controller.sv ====
`timescale 1ns/1ps
`include "cr_params.svh"

module interrupt_controller
    import cr_pkg::*;
(
    input                                   clk,
    input                                   reset,
    input [`CR_NUM_INTERRUPTS - 1:0]        interrupt_req,
    input                                   wr_en,
    input thread_idx_t                      wr_thread,
    input control_register_t                wr_index,
    input scalar_t                          wr_val,
    output logic [`CR_THREADS - 1:0]        interrupt_pending,
    output logic [`CR_NUM_INTERRUPTS - 1:0] pending_bits[`CR_THREADS],
    output logic [`CR_NUM_INTERRUPTS - 1:0] mask_bits[`CR_THREADS],
    output logic [`CR_NUM_INTERRUPTS - 1:0] trigger_type
);
    localparam int N = `CR_NUM_INTERRUPTS;

    logic [N - 1:0] req_prev;
    logic [N - 1:0] req_edge;
    logic [N - 1:0] edge_latched[`CR_THREADS];
    logic [N - 1:0] wr_bits;
    logic [`CR_THREADS - 1:0] ack_sel;

    assign wr_bits = wr_val[N - 1:0];
    assign req_edge = interrupt_req & ~req_prev;

    always_comb
    begin
        for (int t = 0; t < `CR_THREADS; t++)
        begin
            ack_sel[t] = wr_en && wr_index == CR_INTERRUPT_ACK
                && wr_thread == thread_idx_t'(t);
            // Trigger type 1 follows the level, 0 uses the edge latch
            pending_bits[t] = (trigger_type & interrupt_req)
                | (~trigger_type & edge_latched[t]);
            interrupt_pending[t] = |(pending_bits[t] & mask_bits[t]);
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            req_prev <= '0;
            trigger_type <= '0;
            for (int t = 0; t < `CR_THREADS; t++)
            begin
                edge_latched[t] <= '0;
                mask_bits[t] <= '0;
            end
        end
        else
        begin
            req_prev <= interrupt_req;
            if (wr_en && wr_index == CR_INTERRUPT_TRIGGER)
                trigger_type <= wr_bits;
            if (wr_en && wr_index == CR_INTERRUPT_MASK)
                mask_bits[wr_thread] <= wr_bits;

            // Every thread sees the same edges, acks are per thread
            for (int t = 0; t < `CR_THREADS; t++)
                edge_latched[t] <= (edge_latched[t] & ~(wr_bits & {N{ack_sel[t]}})) | req_edge;
        end
    end
endmodule

// ==== design/trap_state.sv ====
`timescale 1ns/1ps
`include "cr_params.svh"

module trap_state
    import cr_pkg::*;
(
    input                       clk,
    input                       reset,
    input                       trap_valid,
    input trap_event_t          trap,
    input                       eret_valid,
    input thread_idx_t          eret_thread,
    input                       wr_en,
    input thread_idx_t          wr_thread,
    input control_register_t    wr_index,
    input scalar_t              wr_val,
    output flags_t              flags[`CR_THREADS],
    output flags_t              saved_flags[`CR_THREADS],
    output scalar_t             eret_address[`CR_THREADS],
    output trap_cause_t         trap_cause[`CR_THREADS],
    output scalar_t             trap_address[`CR_THREADS],
    output subcycle_t           subcycle[`CR_THREADS],
    output scalar_t             scratchpad0[`CR_THREADS],
    output scalar_t             scratchpad1[`CR_THREADS]
);
    // Everything saved per nesting level
    typedef struct packed {
        trap_cause_t cause;
        scalar_t pc;
        scalar_t access_addr;
        flags_t flags;
        subcycle_t subcycle;
        scalar_t scratchpad0;
        scalar_t scratchpad1;
    } trap_level_t;

    // Threads come out of reset in supervisor mode with the MMU off
    localparam flags_t RESET_FLAGS = '{supervisor: 1'b1, mmu_en: 1'b0, interrupt_en: 1'b0};
    localparam trap_level_t RESET_LEVEL = '{
        cause: TRAP_CAUSE_RESET,
        pc: '0,
        access_addr: '0,
        flags: RESET_FLAGS,
        subcycle: '0,
        scratchpad0: '0,
        scratchpad1: '0
    };

    // Level 0 is the live trap context, level 1 the one it interrupted
    trap_level_t level[2][`CR_THREADS];

    always_comb
    begin
        for (int t = 0; t < `CR_THREADS; t++)
        begin
            saved_flags[t] = level[0][t].flags;
            eret_address[t] = level[0][t].pc;
            trap_cause[t] = level[0][t].cause;
            trap_address[t] = level[0][t].access_addr;
            subcycle[t] = level[0][t].subcycle;
            scratchpad0[t] = level[0][t].scratchpad0;
            scratchpad1[t] = level[0][t].scratchpad1;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int t = 0; t < `CR_THREADS; t++)
            begin
                flags[t] <= RESET_FLAGS;
                level[0][t] <= RESET_LEVEL;
                level[1][t] <= RESET_LEVEL;
            end
        end
        else
        begin
            if (trap_valid)
            begin
                level[1][trap.thread] <= level[0][trap.thread];
                level[0][trap.thread].cause <= trap.cause;
                level[0][trap.thread].pc <= trap.pc;
                level[0][trap.thread].access_addr <= trap.access_addr;
                level[0][trap.thread].flags <= flags[trap.thread];
                level[0][trap.thread].subcycle <= trap.subcycle;

                // Enter the handler in supervisor mode with interrupts off
                flags[trap.thread].supervisor <= 1'b1;
                flags[trap.thread].interrupt_en <= 1'b0;
                if (trap.cause.trap_type == TT_TLB_MISS)
                    flags[trap.thread].mmu_en <= 1'b0;
            end
            else if (eret_valid)
            begin
                flags[eret_thread] <= level[0][eret_thread].flags;
                level[0][eret_thread] <= level[1][eret_thread];
            end

            // Placed last so a write beats a trap on the same field
            if (wr_en)
            begin
                case (wr_index)
                    CR_FLAGS:       flags[wr_thread] <= flags_t'(wr_val[2:0]);
                    CR_SAVED_FLAGS: level[0][wr_thread].flags <= flags_t'(wr_val[2:0]);
                    CR_TRAP_PC:     level[0][wr_thread].pc <= wr_val;
                    CR_SCRATCHPAD0: level[0][wr_thread].scratchpad0 <= wr_val;
                    CR_SCRATCHPAD1: level[0][wr_thread].scratchpad1 <= wr_val;
                    CR_SUBCYCLE:    level[0][wr_thread].subcycle <= subcycle_t'(wr_val);
                    default:
                        ;
                endcase
            end
        end
    end
endmodule

// ==== design/creg_access.sv ====
`timescale 1ns/1ps
`include "cr_params.svh"

module creg_access
    import cr_pkg::*;
(
    input                                   clk,
    input                                   reset,
    input                                   req_not_empty,
    input creg_req_t                        req_head,
    input                                   rsp_full,
    output logic                            req_pop,
    output logic                            rsp_push,
    output creg_rsp_t                       rsp_data,
    output logic                            wr_en,
    output thread_idx_t                     wr_thread,
    output control_register_t               wr_index,
    output scalar_t                         wr_val,
    input flags_t                           flags[`CR_THREADS],
    input flags_t                           saved_flags[`CR_THREADS],
    input scalar_t                          eret_address[`CR_THREADS],
    input trap_cause_t                      trap_cause[`CR_THREADS],
    input scalar_t                          trap_address[`CR_THREADS],
    input subcycle_t                        subcycle[`CR_THREADS],
    input scalar_t                          scratchpad0[`CR_THREADS],
    input scalar_t                          scratchpad1[`CR_THREADS],
    input [`CR_NUM_INTERRUPTS - 1:0]        pending_bits[`CR_THREADS],
    input [`CR_NUM_INTERRUPTS - 1:0]        mask_bits[`CR_THREADS],
    input [`CR_NUM_INTERRUPTS - 1:0]        trigger_type,
    output logic [`CR_ASID_WIDTH - 1:0]     current_asid[`CR_THREADS],
    output scalar_t                         trap_handler,
    output scalar_t                         tlb_miss_handler
);
    scalar_t cycle_count;
    scalar_t page_dir[`CR_THREADS];
    scalar_t read_val;
    logic read_stall;

    // A read needs a free response slot, counting the one still being pushed
    assign read_stall = !req_head.write && (rsp_full || rsp_push);
    assign req_pop = req_not_empty && !read_stall;
    assign wr_en = req_pop && req_head.write;
    assign wr_thread = req_head.thread;
    assign wr_index = req_head.index;
    assign wr_val = req_head.value;

    always_comb
    begin
        case (wr_index)
            CR_FLAGS:             read_val = scalar_t'(flags[wr_thread]);
            CR_SAVED_FLAGS:       read_val = scalar_t'(saved_flags[wr_thread]);
            CR_THREAD_ID:
                read_val = (scalar_t'(`CR_CORE_ID) << $bits(thread_idx_t)) | scalar_t'(wr_thread);
            CR_TRAP_PC:           read_val = eret_address[wr_thread];
            CR_TRAP_CAUSE:        read_val = scalar_t'(trap_cause[wr_thread]);
            CR_TRAP_ADDRESS:      read_val = trap_address[wr_thread];
            CR_TRAP_HANDLER:      read_val = trap_handler;
            CR_TLB_MISS_HANDLER:  read_val = tlb_miss_handler;
            CR_CYCLE_COUNT:       read_val = cycle_count;
            CR_SCRATCHPAD0:       read_val = scratchpad0[wr_thread];
            CR_SCRATCHPAD1:       read_val = scratchpad1[wr_thread];
            CR_SUBCYCLE:          read_val = scalar_t'(subcycle[wr_thread]);
            CR_CURRENT_ASID:      read_val = scalar_t'(current_asid[wr_thread]);
            CR_PAGE_DIR:          read_val = page_dir[wr_thread];
            CR_INTERRUPT_MASK:    read_val = scalar_t'(mask_bits[wr_thread]);
            CR_INTERRUPT_TRIGGER: read_val = scalar_t'(trigger_type);
            CR_INTERRUPT_PENDING: read_val = scalar_t'(pending_bits[wr_thread]);
            default:              read_val = '1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (req_pop && !req_head.write)
            rsp_data <= '{thread: wr_thread, index: wr_index, data: read_val};
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            cycle_count <= '0;
            trap_handler <= '0;
            tlb_miss_handler <= '0;
            rsp_push <= 1'b0;
            for (int t = 0; t < `CR_THREADS; t++)
            begin
                current_asid[t] <= '0;
                page_dir[t] <= '0;
            end
        end
        else
        begin
            cycle_count <= cycle_count + 1'b1;
            rsp_push <= req_pop && !req_head.write;
            if (wr_en)
            begin
                case (wr_index)
                    CR_TRAP_HANDLER:     trap_handler <= wr_val;
                    CR_TLB_MISS_HANDLER: tlb_miss_handler <= wr_val;
                    CR_CURRENT_ASID:     current_asid[wr_thread] <= wr_val[`CR_ASID_WIDTH - 1:0];
                    CR_PAGE_DIR:         page_dir[wr_thread] <= wr_val;
                    default:
                        ;
                endcase
            end
        end
    end
endmodule

// ==== design/control_registers_top.sv ====
`timescale 1ns/1ps
`include "cr_params.svh"

module control_registers_top
    import cr_pkg::*;
(
    input                                   clk,
    input                                   reset,
    input                                   req_valid,
    input creg_req_t                        req,
    output logic                            req_credit,
    output logic                            rsp_valid,
    output creg_rsp_t                       rsp,
    input                                   rsp_credit,
    input                                   trap_valid,
    input trap_event_t                      trap,
    input                                   eret_valid,
    input thread_idx_t                      eret_thread,
    input [`CR_NUM_INTERRUPTS - 1:0]        interrupt_req,
    output logic [`CR_THREADS - 1:0]        interrupt_pending,
    output flags_t                          flags[`CR_THREADS],
    output scalar_t                         eret_address[`CR_THREADS],
    output logic [`CR_ASID_WIDTH - 1:0]     current_asid[`CR_THREADS],
    output scalar_t                         trap_handler,
    output scalar_t                         tlb_miss_handler
);
    localparam int CREDIT_W = $clog2(`CR_RSP_DEPTH + 1);

    creg_req_t req_head;
    logic req_not_empty;
    logic req_pop;
    creg_rsp_t rsp_data;
    creg_rsp_t rsp_head;
    logic rsp_push;
    logic rsp_not_empty;
    logic rsp_full;
    logic rsp_pop;
    logic [CREDIT_W - 1:0] rsp_credits;
    logic wr_en;
    thread_idx_t wr_thread;
    control_register_t wr_index;
    scalar_t wr_val;
    flags_t saved_flags[`CR_THREADS];
    trap_cause_t trap_cause[`CR_THREADS];
    scalar_t trap_address[`CR_THREADS];
    subcycle_t subcycle[`CR_THREADS];
    scalar_t scratchpad0[`CR_THREADS];
    scalar_t scratchpad1[`CR_THREADS];
    logic [`CR_NUM_INTERRUPTS - 1:0] pending_bits[`CR_THREADS];
    logic [`CR_NUM_INTERRUPTS - 1:0] mask_bits[`CR_THREADS];
    logic [`CR_NUM_INTERRUPTS - 1:0] trigger_type;

    credit_fifo #(.payload_t(creg_req_t), .DEPTH(`CR_REQ_DEPTH)) req_queue (
        .clk, .reset, .push(req_valid), .push_data(req), .pop(req_pop),
        .pop_data(req_head), .not_empty(req_not_empty), .full(),
        .credit_return(req_credit));

    // Registered pop strobe of the response queue is the response valid
    credit_fifo #(.payload_t(creg_rsp_t), .DEPTH(`CR_RSP_DEPTH)) rsp_queue (
        .clk, .reset, .push(rsp_push), .push_data(rsp_data), .pop(rsp_pop),
        .pop_data(rsp_head), .not_empty(rsp_not_empty), .full(rsp_full),
        .credit_return(rsp_valid));

    creg_access creg_access_i (.*);

    trap_state trap_state_i (.*);

    interrupt_controller interrupt_controller_i (.*);

    // Send only while the receiver has room
    assign rsp_pop = rsp_not_empty && rsp_credits != '0;

    always_ff @(posedge clk)
    begin
        if (rsp_pop)
            rsp <= rsp_head;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            rsp_credits <= CREDIT_W'(`CR_RSP_DEPTH);
        else
            rsp_credits <= rsp_credits + CREDIT_W'(rsp_credit) - CREDIT_W'(rsp_pop);
    end
endmodule

// ==== verification/cr_tb.sv ====
`timescale 1ns/1ps
`include "cr_params.svh"

module cr_tb
    import cr_pkg::*;
();
    // About 600 cycles of tests, with a wide margin
    localparam int MAX_CYCLES = 3000;

    logic clk = 1'b0;
    logic reset;
    logic req_valid;
    creg_req_t req;
    logic req_credit;
    logic rsp_valid;
    creg_rsp_t rsp;
    logic rsp_credit;
    logic trap_valid;
    trap_event_t trap;
    logic eret_valid;
    thread_idx_t eret_thread;
    logic [`CR_NUM_INTERRUPTS - 1:0] interrupt_req;
    logic [`CR_THREADS - 1:0] interrupt_pending;
    flags_t flags[`CR_THREADS];
    scalar_t eret_address[`CR_THREADS];
    logic [`CR_ASID_WIDTH - 1:0] current_asid[`CR_THREADS];
    scalar_t trap_handler;
    scalar_t tlb_miss_handler;

    logic [15:0] lfsr_state;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int req_credits = `CR_REQ_DEPTH;
    int credit_pulses = 0;
    int rsp_count = 0;
    int owed = 0;
    logic hold_credits = 1'b0;
    creg_rsp_t rsp_seen[$];
    creg_rsp_t exp_q[$];

    control_registers_top control_registers_top_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output scalar_t w);
        w = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // Advance to just after the next edge and do the channel bookkeeping
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (req_credit)
        begin
            req_credits++;
            credit_pulses++;
        end
        if (rsp_valid)
        begin
            rsp_seen.push_back(rsp);
            rsp_count++;
            owed++;
        end
        if (!hold_credits && owed > 0)
        begin
            rsp_credit = 1'b1;
            owed--;
        end
        else
            rsp_credit = 1'b0;
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic compare_scalar(input string name, input scalar_t got, input scalar_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic compare_flags(input string name, input flags_t got, input flags_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic compare_rsp(input creg_rsp_t got, input creg_rsp_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %0t: rsp is thread %0d index %0d data %h, expected %0d %0d %h",
                $time, got.thread, got.index, got.data, want.thread, want.index, want.data);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0)
            $display("%s: passed", name);
        else
            $display("%s: failed with %0d errors", name, errors - err0);
    endtask

    task automatic send_request(input logic wr, input thread_idx_t t,
        input control_register_t idx, input scalar_t v);
        while (req_credits == 0)
            next_cycle();
        req = '{write: wr, thread: t, index: idx, value: v};
        req_valid = 1'b1;
        req_credits--;
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic write_reg(input thread_idx_t t, input control_register_t idx,
        input scalar_t v);
        send_request(1'b1, t, idx, v);
    endtask

    task automatic read_reg(input thread_idx_t t, input control_register_t idx,
        output scalar_t data);
        creg_rsp_t got;
        send_request(1'b0, t, idx, '0);
        while (rsp_seen.size() == 0)
            next_cycle();
        got = rsp_seen.pop_front();
        compare_scalar("rsp.thread", scalar_t'(got.thread), scalar_t'(t));
        compare_scalar("rsp.index", scalar_t'(got.index), scalar_t'(idx));
        data = got.data;
    endtask

    task automatic check_read(input thread_idx_t t, input control_register_t idx,
        input scalar_t want);
        scalar_t got;
        read_reg(t, idx, got);
        compare_scalar($sformatf("%s thread %0d", idx.name(), t), got, want);
    endtask

    task automatic check_responses();
        while (exp_q.size() > 0)
        begin
            if (rsp_seen.size() == 0)
            begin
                report_problem("fewer responses arrived than reads were sent");
                exp_q.delete();
            end
            else
                compare_rsp(rsp_seen.pop_front(), exp_q.pop_front());
        end
    endtask

    task automatic raise_trap(input thread_idx_t t, input trap_cause_t cause,
        input scalar_t pc, input scalar_t addr);
        trap = '{thread: t, cause: cause, pc: pc, access_addr: addr, subcycle: '0};
        trap_valid = 1'b1;
        next_cycle();
        trap_valid = 1'b0;
    endtask

    task automatic return_from_trap(input thread_idx_t t);
        eret_thread = t;
        eret_valid = 1'b1;
        next_cycle();
        eret_valid = 1'b0;
    endtask

    task automatic reset_values();
        int err0;
        trap_cause_t reset_cause;
        flags_t reset_flags;
        scalar_t first;
        scalar_t second;
        err0 = errors;
        reset_cause = '{is_store: 1'b0, is_cache_control: 1'b0, trap_type: TT_RESET};
        reset_flags = '{supervisor: 1'b1, mmu_en: 1'b0, interrupt_en: 1'b0};
        compare_scalar("req_credit", scalar_t'(req_credit), '0);
        compare_scalar("rsp_valid", scalar_t'(rsp_valid), '0);
        compare_scalar("interrupt_pending", scalar_t'(interrupt_pending), '0);
        for (int t = 0; t < `CR_THREADS; t++)
        begin
            compare_flags($sformatf("flags[%0d]", t), flags[t], reset_flags);
            check_read(thread_idx_t'(t), CR_FLAGS, 32'd4);
            check_read(thread_idx_t'(t), CR_THREAD_ID, scalar_t'(`CR_CORE_ID * 4 + t));
            check_read(thread_idx_t'(t), CR_TRAP_CAUSE, scalar_t'(reset_cause));
        end
        // Index 31 is not a defined register
        check_read(2'd0, control_register_t'(5'd31), 32'hffff_ffff);
        read_reg(2'd0, CR_CYCLE_COUNT, first);
        read_reg(2'd0, CR_CYCLE_COUNT, second);
        if (second <= first)
            report_problem("cycle counter did not advance between two reads");
        end_test("reset values", err0);
    endtask

    task automatic register_writes();
        int err0;
        control_register_t idx_list[6];
        scalar_t values[6];
        scalar_t want;
        scalar_t t_word;
        scalar_t asid_mask;
        thread_idx_t t;
        err0 = errors;
        idx_list = '{CR_SCRATCHPAD0, CR_SCRATCHPAD1, CR_TRAP_HANDLER,
            CR_TLB_MISS_HANDLER, CR_PAGE_DIR, CR_CURRENT_ASID};
        asid_mask = (scalar_t'(1) << `CR_ASID_WIDTH) - 1;
        random_bits(2, t_word);
        t = thread_idx_t'(t_word);
        for (int i = 0; i < 6; i++)
        begin
            random_bits(32, values[i]);
            write_reg(t, idx_list[i], values[i]);
            want = idx_list[i] == CR_CURRENT_ASID ? values[i] & asid_mask : values[i];
            check_read(t, idx_list[i], want);
        end
        compare_scalar("current_asid", scalar_t'(current_asid[t]), values[5] & asid_mask);
        compare_scalar("trap_handler", trap_handler, values[2]);
        compare_scalar("tlb_miss_handler", tlb_miss_handler, values[3]);
        end_test("register writes", err0);
    endtask

    task automatic nested_traps();
        int err0;
        thread_idx_t t;
        scalar_t pc1;
        scalar_t addr1;
        scalar_t pc2;
        scalar_t addr2;
        trap_cause_t cause1;
        trap_cause_t cause2;
        flags_t user_flags;
        flags_t handler_flags;
        err0 = errors;
        t = 2'd1;
        random_bits(32, pc1);
        random_bits(32, addr1);
        random_bits(32, pc2);
        random_bits(32, addr2);
        cause1 = '{is_store: 1'b1, is_cache_control: 1'b0, trap_type: TT_PAGE_FAULT};
        cause2 = '{is_store: 1'b0, is_cache_control: 1'b0, trap_type: TT_TLB_MISS};
        user_flags = '{supervisor: 1'b0, mmu_en: 1'b1, interrupt_en: 1'b1};
        handler_flags = '{supervisor: 1'b1, mmu_en: 1'b1, interrupt_en: 1'b1};
        write_reg(t, CR_FLAGS, scalar_t'(user_flags));
        check_read(t, CR_FLAGS, scalar_t'(user_flags));

        // A page fault leaves the MMU on
        raise_trap(t, cause1, pc1, addr1);
        compare_flags("flags[1]", flags[t], '{supervisor: 1'b1, mmu_en: 1'b1, interrupt_en: 1'b0});
        compare_scalar("eret_address[1]", eret_address[t], pc1);

        // Handler turns interrupts back on, then takes a TLB miss
        write_reg(t, CR_FLAGS, scalar_t'(handler_flags));
        check_read(t, CR_FLAGS, scalar_t'(handler_flags));
        raise_trap(t, cause2, pc2, addr2);
        compare_flags("flags[1]", flags[t], '{supervisor: 1'b1, mmu_en: 1'b0, interrupt_en: 1'b0});
        compare_scalar("eret_address[1]", eret_address[t], pc2);
        check_read(t, CR_TRAP_CAUSE, scalar_t'(cause2));
        check_read(t, CR_TRAP_ADDRESS, addr2);
        check_read(t, CR_SAVED_FLAGS, scalar_t'(handler_flags));

        return_from_trap(t);
        compare_flags("flags[1]", flags[t], handler_flags);
        compare_scalar("eret_address[1]", eret_address[t], pc1);
        check_read(t, CR_TRAP_PC, pc1);
        check_read(t, CR_TRAP_CAUSE, scalar_t'(cause1));
        check_read(t, CR_TRAP_ADDRESS, addr1);
        check_read(t, CR_SAVED_FLAGS, scalar_t'(user_flags));

        return_from_trap(t);
        compare_flags("flags[1]", flags[t], user_flags);
        end_test("nested traps", err0);
    endtask

    task automatic interrupts();
        int err0;
        int line;
        scalar_t w;
        scalar_t bit_mask;
        err0 = errors;
        random_bits(4, w);
        line = int'(w[3:0]);
        bit_mask = scalar_t'(1) << line;
        write_reg(2'd2, CR_INTERRUPT_MASK, bit_mask);
        check_read(2'd2, CR_INTERRUPT_MASK, bit_mask);

        // One pulse, latched by every thread, pending only where unmasked
        interrupt_req[line] = 1'b1;
        next_cycle();
        compare_scalar("interrupt_pending", scalar_t'(interrupt_pending), 32'h4);
        interrupt_req[line] = 1'b0;
        repeat (5)
            next_cycle();
        compare_scalar("interrupt_pending", scalar_t'(interrupt_pending), 32'h4);
        check_read(2'd2, CR_INTERRUPT_PENDING, bit_mask);
        check_read(2'd3, CR_INTERRUPT_PENDING, bit_mask);

        write_reg(2'd2, CR_INTERRUPT_ACK, bit_mask);
        check_read(2'd2, CR_INTERRUPT_PENDING, '0);
        compare_scalar("interrupt_pending", scalar_t'(interrupt_pending), '0);
        check_read(2'd3, CR_INTERRUPT_PENDING, bit_mask);
        write_reg(2'd3, CR_INTERRUPT_ACK, bit_mask);
        check_read(2'd3, CR_INTERRUPT_PENDING, '0);

        // Level triggered from here on
        write_reg(2'd0, CR_INTERRUPT_TRIGGER, bit_mask);
        check_read(2'd0, CR_INTERRUPT_TRIGGER, bit_mask);
        interrupt_req[line] = 1'b1;
        #1;
        compare_scalar("interrupt_pending", scalar_t'(interrupt_pending), 32'h4);
        next_cycle();
        check_read(2'd2, CR_INTERRUPT_PENDING, bit_mask);
        interrupt_req[line] = 1'b0;
        #1;
        compare_scalar("interrupt_pending", scalar_t'(interrupt_pending), '0);
        next_cycle();
        check_read(2'd2, CR_INTERRUPT_PENDING, '0);
        end_test("interrupts", err0);
    endtask

    task automatic queue_thread_id_read(input int i);
        thread_idx_t t;
        t = thread_idx_t'(i % `CR_THREADS);
        send_request(1'b0, t, CR_THREAD_ID, '0);
        exp_q.push_back('{thread: t, index: CR_THREAD_ID,
            data: scalar_t'(`CR_CORE_ID * 4 + i % `CR_THREADS)});
    endtask

    task automatic credit_flow();
        int err0;
        int pulses_before;
        int rsp_before;
        err0 = errors;
        while (owed > 0)
            next_cycle();
        next_cycle();
        hold_credits = 1'b1;

        // Use up the DUT's response credits
        for (int i = 0; i < `CR_RSP_DEPTH; i++)
            queue_thread_id_read(i);
        while (rsp_seen.size() < `CR_RSP_DEPTH)
            next_cycle();
        check_responses();

        pulses_before = credit_pulses;
        rsp_before = rsp_count;
        for (int i = 0; i < `CR_RSP_DEPTH + `CR_REQ_DEPTH; i++)
            queue_thread_id_read(i);
        repeat (20)
            next_cycle();
        if (rsp_count != rsp_before)
            report_problem("a response was sent while the receiver held every credit");
        if (credit_pulses - pulses_before > `CR_RSP_DEPTH)
            report_problem("more request credits came back than the response queue holds");

        hold_credits = 1'b0;
        while (rsp_seen.size() < `CR_RSP_DEPTH + `CR_REQ_DEPTH)
            next_cycle();
        check_responses();
        while (owed > 0 || req_credits < `CR_REQ_DEPTH)
            next_cycle();
        end_test("credit flow", err0);
    endtask

    initial
    begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_credit = 1'b0;
        trap_valid = 1'b0;
        trap = '0;
        eret_valid = 1'b0;
        eret_thread = '0;
        interrupt_req = '0;
        lfsr_state = 16'd60;
        repeat (16)
            @(posedge clk);
        #1;
        reset = 1'b0;

        reset_values();
        register_writes();
        nested_traps();
        interrupts();
        credit_flow();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end
endmodule

// ==== build.f ====
+incdir+include
design/cr_pkg.sv
design/credit_fifo.sv
design/interrupt_controller.sv
design/trap_state.sv
design/creg_access.sv
design/control_registers_top.sv
verification/cr_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = cr_tb
FILELIST = build.f
OBJ_DIR = obj_dir
PASS_TEXT = TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
